// File: all.f
+incdir+logic
logic/jtag_tap_pkg.sv
logic/jtag_dbg_pkg.sv
logic/jtag_tap.sv
logic/jtag_dr_chain.sv
logic/jtag_wb_master.sv
logic/jtag_debug_top.sv
bench/jtag_debug_tb.sv

// File: bench/jtag_debug_tb.sv
// Testbench for the JTAG debug port
// Bit-bangs TCK at one eighth of clk, runs a table of IR and DR scans and
// answers Wishbone cycles from a 256-word memory model with random ack delay
`timescale 1ns/100ps
`include "jtag_params.svh"

module jtag_debug_tb;
    import jtag_tap_pkg::*;

    // One scan table row, DR bits are LSB first
    typedef struct packed {
        logic [`JTAG_IR_LEN-1:0] ir;
        int                      len;
        logic [63:0]             din;
        logic [63:0]             dout;
    } scan_row_t;

    localparam int NUM_ROWS    = 8;
    localparam int BUS_TIMEOUT = 200;

    logic                 clk;
    logic                 rst_n;
    logic                 tck_i;
    logic                 tms_i;
    logic                 td_i;
    logic [`WB_DAT_W-1:0] wb_dat_i;
    logic                 wb_ack_i;
    logic                 td_o;
    logic                 tdo_oe_o;
    logic                 wb_cyc_o;
    logic                 wb_stb_o;
    logic                 wb_we_o;
    logic [`WB_ADR_W-1:0] wb_adr_o;
    logic [`WB_DAT_W-1:0] wb_dat_o;

    logic [`WB_DAT_W-1:0]    mem [256];
    int                      errors     = 0;
    int                      checks     = 0;
    int                      bus_cycles = 0;
    integer                  seed       = 31;
    integer                  rnd;
    scan_row_t               scan_table [NUM_ROWS];
    logic [`JTAG_IR_LEN-1:0] ir_cap;
    logic [63:0]             dr_out;
    logic                    tdo_bit;
    int                      cycles_before;
    logic [`DBG_ADDR_W-1:0]  row_addr;

    jtag_debug_top u_jtag_debug_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .tck_i    (tck_i),
        .tms_i    (tms_i),
        .td_i     (td_i),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .td_o     (td_o),
        .tdo_oe_o (tdo_oe_o),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // Wishbone memory model
    // --------------------------------------------------

    // Ack comes 0 to 3 clk after the request, ack lasts one clk
    initial begin : wb_memory_model
        int wait_left;
        wb_ack_i  = 1'b0;
        wb_dat_i  = '0;
        wait_left = 0;
        // Every byte lane carries the address
        for (int a = 0; a < 256; a++) begin
            mem[a] = {~a[7:0], a[7:0], a[7:0] ^ 8'h5A, a[7:0]};
        end
        forever begin
            @(negedge clk);
            if (wb_ack_i) begin
                wb_ack_i = 1'b0;
            end else if (rst_n && wb_cyc_o && wb_stb_o) begin
                if (wait_left == 0) begin
                    if (wb_we_o) begin
                        mem[wb_adr_o] = wb_dat_o;
                    end else begin
                        wb_dat_i = mem[wb_adr_o];
                    end
                    wb_ack_i   = 1'b1;
                    bus_cycles = bus_cycles + 1;
                end else begin
                    wait_left = wait_left - 1;
                end
            end else begin
                rnd       = $random(seed);
                wait_left = rnd & 3;
            end
        end
    end

    // --------------------------------------------------
    // Checks and TAP access
    // --------------------------------------------------

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks = checks + 1;
        if (got !== expected) begin
            errors = errors + 1;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    // Low half then high half, TDO sampled just before the rising edge
    task automatic tck_cycle(input logic tms, input logic tdi, input logic oe_exp,
                             output logic tdo);
        @(negedge clk);
        tck_i = 1'b0;
        tms_i = tms;
        td_i  = tdi;
        repeat (3) @(negedge clk);
        tdo = td_o;
        check_value("tdo_oe_o", 64'(tdo_oe_o), 64'(oe_exp));
        @(negedge clk);
        tck_i = 1'b1;
        repeat (3) @(negedge clk);
    endtask

    // Idle to Idle through the IR column
    task automatic scan_ir(input logic [`JTAG_IR_LEN-1:0] instr,
                           output logic [`JTAG_IR_LEN-1:0] captured);
        logic tdo;
        tck_cycle(1'b1, 1'b0, 1'b0, tdo);
        tck_cycle(1'b1, 1'b0, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, 1'b0, tdo);
        for (int i = 0; i < `JTAG_IR_LEN; i++) begin
            tck_cycle(i == `JTAG_IR_LEN - 1, instr[i], 1'b1, tdo);
            captured[i] = tdo;
        end
        tck_cycle(1'b1, 1'b0, 1'b0, tdo);
        // IR latches on this falling edge
        tck_cycle(1'b0, 1'b0, 1'b0, tdo);
    endtask

    // Idle to Idle through the DR column
    task automatic scan_dr(input int len, input logic [63:0] din,
                           output logic [63:0] dout);
        logic tdo;
        dout = '0;
        tck_cycle(1'b1, 1'b0, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, 1'b0, tdo);
        for (int i = 0; i < len; i++) begin
            tck_cycle(i == len - 1, din[i], 1'b1, tdo);
            dout[i] = tdo;
        end
        tck_cycle(1'b1, 1'b0, 1'b0, tdo);
        tck_cycle(1'b0, 1'b0, 1'b0, tdo);
    endtask

    task automatic wait_bus_idle();
        int n;
        n = 0;
        while (wb_cyc_o && (n < BUS_TIMEOUT)) begin
            @(negedge clk);
            n = n + 1;
        end
        if (wb_cyc_o) begin
            errors = errors + 1;
            $display("Timeout: the Wishbone cycle never received an ack");
        end else begin
            // Strobe drops together with cyc on ack
            check_value("wb_stb_o", 64'(wb_stb_o), 64'd0);
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    initial begin
        rst_n = 1'b0;
        tck_i = 1'b0;
        tms_i = 1'b1;
        td_i  = 1'b0;

        // Instruction, DR length, data in, expected data out
        scan_table[0] = '{BYPASS0,    16, 64'hC3A5,        64'h874A};
        scan_table[1] = '{BYPASS1,    12, 64'h5F3,         64'hBE6};
        scan_table[2] = '{5'h0A,      8,  64'h81,          64'h02};
        scan_table[3] = '{IDCODE,     32, 64'h0,           64'h1BEEF0A1};
        // DBG_ACCESS rows: we[40], addr[39:32], data[31:0]
        scan_table[4] = '{DBG_ACCESS, 41, 64'h13CDEADBEEF, 64'h0};
        scan_table[5] = '{DBG_ACCESS, 41, 64'h03C00000000, 64'h0};
        scan_table[6] = '{DBG_ACCESS, 41, 64'h01000000000, 64'h0DEADBEEF};
        scan_table[7] = '{DBG_ACCESS, 41, 64'h1A012345678, 64'h0EF104A10};

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // IDCODE is selected straight out of reset
        tck_cycle(1'b0, 1'b0, 1'b0, tdo_bit);
        scan_dr(32, 64'h0, dr_out);
        check_value("td_o (IDCODE after reset)", dr_out, 64'(`JTAG_IDCODE));

        for (int row = 0; row < NUM_ROWS; row++) begin
            scan_ir(scan_table[row].ir, ir_cap);
            check_value("td_o (IR capture)", 64'(ir_cap), 64'(`JTAG_IR_CAPTURE));
            cycles_before = bus_cycles;
            scan_dr(scan_table[row].len, scan_table[row].din, dr_out);
            wait_bus_idle();
            check_value($sformatf("td_o (DR row %0d)", row), dr_out, scan_table[row].dout);
            if (scan_table[row].ir == DBG_ACCESS) begin
                check_value("wb_cyc_o count", 64'(bus_cycles - cycles_before), 64'd1);
                row_addr = scan_table[row].din[`DBG_DATA_W +: `DBG_ADDR_W];
                // A write must land in the model memory
                if (scan_table[row].din[`DBG_DATA_W + `DBG_ADDR_W]) begin
                    check_value("wb_dat_o (memory word)", 64'(mem[row_addr]),
                                64'(scan_table[row].din[`DBG_DATA_W-1:0]));
                end
            end else begin
                check_value("wb_cyc_o count", 64'(bus_cycles - cycles_before), 64'd0);
            end
        end

        // Abort a BYPASS DR scan after two bits with five TMS high clocks
        scan_ir(BYPASS0, ir_cap);
        check_value("td_o (IR capture)", 64'(ir_cap), 64'(`JTAG_IR_CAPTURE));
        tck_cycle(1'b1, 1'b0, 1'b0, tdo_bit);
        tck_cycle(1'b0, 1'b0, 1'b0, tdo_bit);
        tck_cycle(1'b0, 1'b0, 1'b0, tdo_bit);
        tck_cycle(1'b0, 1'b1, 1'b1, tdo_bit);
        tck_cycle(1'b0, 1'b1, 1'b1, tdo_bit);
        // First TMS high still samples inside ShiftDr
        tck_cycle(1'b1, 1'b0, 1'b1, tdo_bit);
        repeat (4) tck_cycle(1'b1, 1'b0, 1'b0, tdo_bit);
        tck_cycle(1'b0, 1'b0, 1'b0, tdo_bit);
        scan_dr(32, 64'h0, dr_out);
        check_value("td_o (IDCODE after TMS reset)", dr_out, 64'(`JTAG_IDCODE));
        wait_bus_idle();

        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: logic/jtag_dbg_pkg.sv
// Bus-side types: debug-access register layout and the status word
// Shared by the DR chain and the Wishbone master
`include "jtag_params.svh"

package jtag_dbg_pkg;

    // Status returned in bits [33:32] of a DBG_ACCESS capture
    typedef struct packed {
        logic overrun;  // update seen while busy, sticky until capture
        logic busy;     // bus cycle still pending
    } dbg_status_t;

    // Field positions in the 41-bit register, LSB first
    localparam int unsigned DBG_DATA_LSB = 0;
    localparam int unsigned DBG_ADDR_LSB = `DBG_DATA_W;
    localparam int unsigned DBG_WE_BIT   = `DBG_DATA_W + `DBG_ADDR_W;

endpackage

// File: logic/jtag_debug_top.sv
// JTAG debug port top level
// TAP, data registers and Wishbone master, all in the clk domain
`timescale 1ns/100ps
`include "jtag_params.svh"

module jtag_debug_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tck_i,
    input  logic                 tms_i,
    input  logic                 td_i,
    input  logic [`WB_DAT_W-1:0] wb_dat_i,
    input  logic                 wb_ack_i,
    output logic                 td_o,
    output logic                 tdo_oe_o,
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output logic                 wb_we_o,
    output logic [`WB_ADR_W-1:0] wb_adr_o,
    output logic [`WB_DAT_W-1:0] wb_dat_o
);
    import jtag_tap_pkg::*;
    import jtag_dbg_pkg::*;

    // TAP to DR chain
    jtag_instr_e             ir;
    logic                    capture_dr;
    logic                    shift_dr;
    logic                    update_dr;
    logic                    shift_ir;
    logic                    tck_negedge;
    logic                    ir_tdo;
    // DR chain to bus master and back
    logic                    cmd_valid;
    logic                    cmd_we;
    logic [`DBG_ADDR_W-1:0]  cmd_addr;
    logic [`DBG_DATA_W-1:0]  cmd_data;
    logic                    status_clr;
    logic [`DBG_DATA_W-1:0]  rdata;
    dbg_status_t             status;

    jtag_tap u_jtag_tap (
        .clk           (clk),
        .rst_n         (rst_n),
        .tck_i         (tck_i),
        .tms_i         (tms_i),
        .td_i          (td_i),
        .ir_o          (ir),
        .capture_dr_o  (capture_dr),
        .shift_dr_o    (shift_dr),
        .update_dr_o   (update_dr),
        .shift_ir_o    (shift_ir),
        .tck_negedge_o (tck_negedge),
        .ir_tdo_o      (ir_tdo)
    );

    jtag_dr_chain u_jtag_dr_chain (
        .clk           (clk),
        .rst_n         (rst_n),
        .td_i          (td_i),
        .ir_i          (ir),
        .capture_dr_i  (capture_dr),
        .shift_dr_i    (shift_dr),
        .update_dr_i   (update_dr),
        .shift_ir_i    (shift_ir),
        .tck_negedge_i (tck_negedge),
        .ir_tdo_i      (ir_tdo),
        .rdata_i       (rdata),
        .status_i      (status),
        .td_o          (td_o),
        .tdo_oe_o      (tdo_oe_o),
        .cmd_valid_o   (cmd_valid),
        .cmd_we_o      (cmd_we),
        .cmd_addr_o    (cmd_addr),
        .cmd_data_o    (cmd_data),
        .status_clr_o  (status_clr)
    );

    jtag_wb_master u_jtag_wb_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid_i  (cmd_valid),
        .cmd_we_i     (cmd_we),
        .cmd_addr_i   (cmd_addr),
        .cmd_data_i   (cmd_data),
        .status_clr_i (status_clr),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .wb_dat_o     (wb_dat_o),
        .rdata_o      (rdata),
        .status_o     (status)
    );

endmodule

// File: logic/jtag_dr_chain.sv
// Data registers behind the TAP: IDCODE, BYPASS and DBG_ACCESS
// Selects the serial output, drives TDO and its enable, and turns each
// DBG_ACCESS update into a command for the Wishbone master
`timescale 1ns/100ps
`include "jtag_params.svh"

module jtag_dr_chain (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      td_i,
    input  jtag_tap_pkg::jtag_instr_e ir_i,
    input  logic                      capture_dr_i,
    input  logic                      shift_dr_i,
    input  logic                      update_dr_i,
    input  logic                      shift_ir_i,
    input  logic                      tck_negedge_i,
    input  logic                      ir_tdo_i,
    input  logic [`DBG_DATA_W-1:0]    rdata_i,
    input  jtag_dbg_pkg::dbg_status_t status_i,
    output logic                      td_o,
    output logic                      tdo_oe_o,
    output logic                      cmd_valid_o,
    output logic                      cmd_we_o,
    output logic [`DBG_ADDR_W-1:0]    cmd_addr_o,
    output logic [`DBG_DATA_W-1:0]    cmd_data_o,
    output logic                      status_clr_o
);
    import jtag_tap_pkg::*;
    import jtag_dbg_pkg::*;

    logic                   sel_idcode;
    logic                   sel_dbg;
    logic                   sel_bypass;
    logic [31:0]            idcode_sr;
    logic                   bypass_q;
    logic [`DBG_DR_LEN-1:0] dbg_sr;
    logic                   dr_lsb;
    logic                   ir_path_q;

    // Unassigned codes fall back to BYPASS
    assign sel_idcode = (ir_i == IDCODE);
    assign sel_dbg    = (ir_i == DBG_ACCESS);
    assign sel_bypass = !sel_idcode && !sel_dbg;

    // --------------------------------------------------
    // Data registers
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (capture_dr_i) begin
            if (sel_idcode) begin
                idcode_sr <= `JTAG_IDCODE;
            end
            if (sel_bypass) begin
                bypass_q <= 1'b0;
            end
            // Read data low, status above it, rest zero
            if (sel_dbg) begin
                dbg_sr <= {{(`DBG_DR_LEN - `DBG_DATA_W - $bits(dbg_status_t)){1'b0}},
                           status_i, rdata_i};
            end
        end else if (shift_dr_i) begin
            if (sel_idcode) begin
                idcode_sr <= {td_i, idcode_sr[31:1]};
            end
            if (sel_bypass) begin
                bypass_q <= td_i;
            end
            if (sel_dbg) begin
                dbg_sr <= {td_i, dbg_sr[`DBG_DR_LEN-1:1]};
            end
        end
    end

    assign dr_lsb = sel_idcode ? idcode_sr[0] : (sel_dbg ? dbg_sr[0] : bypass_q);

    // --------------------------------------------------
    // TDO retiming
    // --------------------------------------------------

    // Every DR scan runs from CaptureDr to UpdateDr, so outside that
    // window any shift falling edge belongs to ShiftIr
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_path_q <= 1'b1;
        end else if (capture_dr_i) begin
            ir_path_q <= 1'b0;
        end else if (update_dr_i) begin
            ir_path_q <= 1'b1;
        end
    end

    // Bit valid from the falling edge to the rising edge that consumes it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            td_o     <= 1'b0;
            tdo_oe_o <= 1'b0;
        end else if (tck_negedge_i) begin
            td_o     <= ir_path_q ? ir_tdo_i : dr_lsb;
            tdo_oe_o <= 1'b1;
        end else if (shift_dr_i || shift_ir_i) begin
            tdo_oe_o <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Command to the bus master
    // --------------------------------------------------

    assign cmd_valid_o  = update_dr_i && sel_dbg;
    assign cmd_we_o     = dbg_sr[DBG_WE_BIT];
    assign cmd_addr_o   = dbg_sr[DBG_ADDR_LSB +: `DBG_ADDR_W];
    assign cmd_data_o   = dbg_sr[DBG_DATA_LSB +: `DBG_DATA_W];
    // Overrun is read out by this capture, then cleared
    assign status_clr_o = capture_dr_i && sel_dbg;

    // The IR cannot change in the clk that issues a command
    a_cmd_in_dbg: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid_o |-> (ir_i == DBG_ACCESS) && $stable(ir_i));

endmodule

// File: logic/jtag_params.svh
// Shared widths and constants for the JTAG debug port
// Included by the packages and by every module that sizes a port from them
`ifndef JTAG_PARAMS_SVH
`define JTAG_PARAMS_SVH

// Instruction register length and the fixed CaptureIr pattern (low bits 01)
`define JTAG_IR_LEN      5
`define JTAG_IR_CAPTURE  5'b00101

// Identification value, LSB set as the standard requires
`define JTAG_IDCODE      32'h1BEEF0A1

// Debug-access register fields
`define DBG_ADDR_W       8
`define DBG_DATA_W       32
`define DBG_DR_LEN       (1 + `DBG_ADDR_W + `DBG_DATA_W)

// Wishbone side follows the debug-access fields one to one
`define WB_ADR_W         `DBG_ADDR_W
`define WB_DAT_W         `DBG_DATA_W

`endif

// File: logic/jtag_tap.sv
// JTAG TAP controller clocked from the system clock
// TCK is sampled on clk, so clk must run at least four times faster than TCK
// Provides the DR strobes, the IR and its serial output to the DR chain
`timescale 1ns/100ps
`include "jtag_params.svh"

module jtag_tap (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      tck_i,
    input  logic                      tms_i,
    input  logic                      td_i,
    output jtag_tap_pkg::jtag_instr_e ir_o,
    output logic                      capture_dr_o,
    output logic                      shift_dr_o,
    output logic                      update_dr_o,
    output logic                      shift_ir_o,
    output logic                      tck_negedge_o,
    output logic                      ir_tdo_o
);
    import jtag_tap_pkg::*;

    logic [1:0]              tck_q;
    logic                    tck_rise;
    logic                    tck_fall;
    tap_state_e              state_q;
    tap_state_e              state_d;
    logic [`JTAG_IR_LEN-1:0] ir_sr_q;
    logic                    capture_ir;
    logic                    update_ir;

    // --------------------------------------------------
    // TCK edge detection
    // --------------------------------------------------

    // Older sample in bit 1, edges show up two clk after the pad
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tck_q <= 2'b00;
        end else begin
            tck_q <= {tck_q[0], tck_i};
        end
    end

    assign tck_rise = (tck_q == 2'b01);
    assign tck_fall = (tck_q == 2'b10);

    // --------------------------------------------------
    // Strobes, one clk wide
    // --------------------------------------------------

    // Capture, shift and DR update act on the rising edge
    assign capture_dr_o = tck_rise && (state_q == CAPTURE_DR);
    assign shift_dr_o   = tck_rise && (state_q == SHIFT_DR);
    assign update_dr_o  = tck_rise && (state_q == UPDATE_DR);
    assign capture_ir   = tck_rise && (state_q == CAPTURE_IR);
    assign shift_ir_o   = tck_rise && (state_q == SHIFT_IR);

    // IR latch takes the falling edge inside UpdateIr
    assign update_ir = tck_fall && (state_q == UPDATE_IR);

    // Falling edges on which TDO presents the next bit
    assign tck_negedge_o = tck_fall && ((state_q == SHIFT_DR) || (state_q == SHIFT_IR));

    // --------------------------------------------------
    // Controller FSM
    // --------------------------------------------------

    always_comb begin
        case (state_q)
            TEST_LOGIC_RESET: state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            // DR column
            SELECT_DR_SCAN:   state_d = tms_i ? SELECT_IR_SCAN   : CAPTURE_DR;
            CAPTURE_DR:       state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
            SHIFT_DR:         state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
            EXIT1_DR:         state_d = tms_i ? UPDATE_DR        : PAUSE_DR;
            PAUSE_DR:         state_d = tms_i ? EXIT2_DR         : PAUSE_DR;
            EXIT2_DR:         state_d = tms_i ? UPDATE_DR        : SHIFT_DR;
            UPDATE_DR:        state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            // IR column
            SELECT_IR_SCAN:   state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
            SHIFT_IR:         state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
            EXIT1_IR:         state_d = tms_i ? UPDATE_IR        : PAUSE_IR;
            PAUSE_IR:         state_d = tms_i ? EXIT2_IR         : PAUSE_IR;
            EXIT2_IR:         state_d = tms_i ? UPDATE_IR        : SHIFT_IR;
            UPDATE_IR:        state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            default:          state_d = TEST_LOGIC_RESET;
        endcase
    end

    // State only moves on a detected rising edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= TEST_LOGIC_RESET;
        end else if (tck_rise) begin
            state_q <= state_d;
        end
    end

    // --------------------------------------------------
    // Instruction register
    // --------------------------------------------------

    // Shift stage, new bits enter at the MSB
    always_ff @(posedge clk) begin
        if (capture_ir) begin
            ir_sr_q <= `JTAG_IR_CAPTURE;
        end else if (shift_ir_o) begin
            ir_sr_q <= {td_i, ir_sr_q[`JTAG_IR_LEN-1:1]};
        end
    end

    // Latch stage, TestLogicReset forces IDCODE
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_o <= IDCODE;
        end else if (state_q == TEST_LOGIC_RESET) begin
            ir_o <= IDCODE;
        end else if (update_ir) begin
            ir_o <= jtag_instr_e'(ir_sr_q);
        end
    end

    assign ir_tdo_o = ir_sr_q[0];

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // State register holds one of the sixteen codes
    a_state_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(state_q));

    // Capture never overlaps a shift, nor is followed by one a clk later
    a_capture_alone: assert property (@(posedge clk) disable iff (!rst_n)
        (capture_dr_o || capture_ir) |->
            !(shift_dr_o || shift_ir_o) ##1 !(shift_dr_o || shift_ir_o));

endmodule

// File: logic/jtag_tap_pkg.sv
// TAP-side types: controller states and instruction opcodes
// Imported by the TAP, the DR chain and the top level
`include "jtag_params.svh"

package jtag_tap_pkg;

    // Sixteen controller states, standard numbering
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'd0,
        RUN_TEST_IDLE    = 4'd1,
        SELECT_DR_SCAN   = 4'd2,
        CAPTURE_DR       = 4'd3,
        SHIFT_DR         = 4'd4,
        EXIT1_DR         = 4'd5,
        PAUSE_DR         = 4'd6,
        EXIT2_DR         = 4'd7,
        UPDATE_DR        = 4'd8,
        SELECT_IR_SCAN   = 4'd9,
        CAPTURE_IR       = 4'd10,
        SHIFT_IR         = 4'd11,
        EXIT1_IR         = 4'd12,
        PAUSE_IR         = 4'd13,
        EXIT2_IR         = 4'd14,
        UPDATE_IR        = 4'd15
    } tap_state_e;

    // Any code not listed here behaves as BYPASS
    typedef enum logic [`JTAG_IR_LEN-1:0] {
        BYPASS0    = 5'd0,
        IDCODE     = 5'd1,
        DBG_ACCESS = 5'd8,
        BYPASS1    = 5'd31
    } jtag_instr_e;

endpackage

// File: logic/jtag_wb_master.sv
// Wishbone classic master for the debug-access register
// Runs one single-word cycle per command and reports read data and status
`timescale 1ns/100ps
`include "jtag_params.svh"

module jtag_wb_master (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_valid_i,
    input  logic                      cmd_we_i,
    input  logic [`DBG_ADDR_W-1:0]    cmd_addr_i,
    input  logic [`DBG_DATA_W-1:0]    cmd_data_i,
    input  logic                      status_clr_i,
    input  logic [`WB_DAT_W-1:0]      wb_dat_i,
    input  logic                      wb_ack_i,
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output logic                      wb_we_o,
    output logic [`WB_ADR_W-1:0]      wb_adr_o,
    output logic [`WB_DAT_W-1:0]      wb_dat_o,
    output logic [`DBG_DATA_W-1:0]    rdata_o,
    output jtag_dbg_pkg::dbg_status_t status_o
);
    typedef enum logic {
        WB_IDLE,
        WB_BUSY
    } wb_state_e;

    wb_state_e state_q;
    logic      overrun_q;

    // --------------------------------------------------
    // Idle/busy FSM and sticky overrun
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= WB_IDLE;
            overrun_q <= 1'b0;
        end else begin
            case (state_q)
                WB_IDLE: if (cmd_valid_i) state_q <= WB_BUSY;
                // No ack means the slave is stalling, keep waiting
                WB_BUSY: if (wb_ack_i) state_q <= WB_IDLE;
                default: state_q <= WB_IDLE;
            endcase
            if (status_clr_i) begin
                overrun_q <= 1'b0;
            end
            // Command during a pending cycle is dropped
            if (cmd_valid_i && (state_q == WB_BUSY)) begin
                overrun_q <= 1'b1;
            end
        end
    end

    // Bus fields held stable for the whole cycle
    always_ff @(posedge clk) begin
        if (cmd_valid_i && (state_q == WB_IDLE)) begin
            wb_we_o  <= cmd_we_i;
            wb_adr_o <= cmd_addr_i;
            wb_dat_o <= cmd_data_i;
        end
    end

    // Read data returned on ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_o <= '0;
        end else if ((state_q == WB_BUSY) && wb_ack_i && !wb_we_o) begin
            rdata_o <= wb_dat_i;
        end
    end

    // cyc and stb rise one clk after the command and drop with ack
    assign wb_cyc_o = (state_q == WB_BUSY);
    assign wb_stb_o = (state_q == WB_BUSY);

    always_comb begin
        status_o.busy    = (state_q == WB_BUSY);
        status_o.overrun = overrun_q;
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_stb_o) |-> wb_cyc_o);

    // Request held unchanged until the slave acks
    a_hold_to_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb_o && !wb_ack_i) |=>
            wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o) && $stable(wb_dat_o));

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the JTAG debug port testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module jtag_debug_tb \
    -f all.f \
    -o jtag_debug_sim

./obj_dir/jtag_debug_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation finished without failures"
